// File: hdl/i2si_pkg.sv
package i2si_pkg;

    localparam int NUM_PORTS   = 2;                     // Independent I2S inputs
    localparam int SAMPLE_W    = 16;                    // Bits per channel sample
    localparam int SRC_W       = 2;                     // Source tag width
    localparam logic [SRC_W-1:0] BIST_SRC = 2'd3;       // Tag of self-test frames

    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

    localparam int BIST_PERIOD = 64;                    // clk cycles between BIST frames
    localparam int BIST_CNT_W  = $clog2(BIST_PERIOD);
    localparam int BIST_W      = 12;                    // Start value and upper limit
    localparam int BIST_INC_W  = 8;

    // Left channel sits in the upper half
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } i2si_frame_t;

    typedef struct packed {
        logic [SRC_W-1:0] src;                          // Port index or BIST_SRC
        i2si_frame_t      frame;
    } i2si_word_t;

endpackage

// File: hdl/i2si_line_if.sv
`timescale 1ns/1ps

interface i2si_line_if;

    logic sck_rise;                                     // One clk cycle per bit clock rise
    logic ws;                                           // Word select, aligned to sck_rise
    logic sd;                                           // Serial data, aligned to sck_rise
    logic en;                                           // Port enable

    modport src (
        output sck_rise, ws, sd, en
    );

    modport dst (
        input sck_rise, ws, sd, en
    );

endinterface

// File: hdl/i2si_synchronizer.sv
`timescale 1ns/1ps

module i2si_synchronizer
    import i2si_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_PORTS-1:0] i2si_sck,
    input  logic [NUM_PORTS-1:0] i2si_ws,
    input  logic [NUM_PORTS-1:0] i2si_sd,
    input  logic                 i2si_en,
    i2si_line_if.src             line [NUM_PORTS]
);

    logic [NUM_PORTS-1:0] sck_q1, sck_q2, sck_q3;
    logic [NUM_PORTS-1:0] ws_q1, ws_q2, ws_q3;
    logic [NUM_PORTS-1:0] sd_q1, sd_q2, sd_q3;
    logic [NUM_PORTS-1:0] rise_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            {sck_q1, sck_q2, sck_q3} <= '0;
            {ws_q1, ws_q2, ws_q3}    <= '0;
            {sd_q1, sd_q2, sd_q3}    <= '0;
            rise_q                   <= '0;
        end
        else
        begin
            {sck_q3, sck_q2, sck_q1} <= {sck_q2, sck_q1, i2si_sck};
            {ws_q3, ws_q2, ws_q1}    <= {ws_q2, ws_q1, i2si_ws};    // Third stage keeps ws
            {sd_q3, sd_q2, sd_q1}    <= {sd_q2, sd_q1, i2si_sd};    // and sd on the strobe
            rise_q                   <= sck_q2 & ~sck_q3;
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        assign line[i].sck_rise = rise_q[i];
        assign line[i].ws       = ws_q3[i];
        assign line[i].sd       = sd_q3[i];
        assign line[i].en       = i2si_en;

        // Bit clock period must be at least four clk cycles
        a_rise_single: assert property (@(posedge clk) disable iff (!rst)
            rise_q[i] |=> (!rise_q[i]) [*3]);
    end

endmodule

// File: hdl/i2si_deserializer.sv
`timescale 1ns/1ps

module i2si_deserializer
    import i2si_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    i2si_line_if.dst    line,
    output i2si_frame_t frame,
    output logic        xfc
);

    logic                active;                        // Locked onto a ws falling edge
    logic                ws_prev;
    logic [SAMPLE_W-1:0] shift;
    logic [SAMPLE_W-1:0] word;
    logic [SAMPLE_W-1:0] left_smp;
    logic                ws_fall;
    logic                ws_rise;
    logic                store_rgt;

    // Philips format: the bit sampled on a ws change is the LSB of the old word
    assign word      = {shift[SAMPLE_W-2:0], line.sd};
    assign ws_fall   = line.sck_rise & ws_prev & ~line.ws;
    assign ws_rise   = line.sck_rise & ~ws_prev & line.ws;
    assign store_rgt = active & line.en & ws_fall;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            active  <= 1'b0;
            ws_prev <= 1'b0;
            xfc     <= 1'b0;
        end
        else
        begin
            xfc <= store_rgt;
            if (line.sck_rise)
                ws_prev <= line.ws;
            if (!line.en)
                active <= 1'b0;                         // Back to idle
            else if (ws_fall)
                active <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line.sck_rise)
            shift <= word;
        if (active && ws_rise)
            left_smp <= word;                           // ws was 0
        if (store_rgt)
        begin
            frame.left  <= left_smp;
            frame.right <= word;
        end
    end

    a_xfc_active: assert property (@(posedge clk) disable iff (!rst)
        xfc |-> active);

endmodule

// File: hdl/i2si_bist_gen.sv
`timescale 1ns/1ps

module i2si_bist_gen
    import i2si_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rf_bist_en,
    input  logic [BIST_W-1:0]     rf_bist_start_val,
    input  logic [BIST_W-1:0]     rf_bist_up_limit,
    input  logic [BIST_INC_W-1:0] rf_bist_inc,
    output i2si_frame_t           bist_frame,
    output logic                  bist_xfc
);

    logic [BIST_CNT_W-1:0] cnt;
    logic [BIST_W-1:0]     val;
    logic [BIST_W:0]       sum;                         // One spare bit, no wrap
    logic                  tick;
    logic [SAMPLE_W-1:0]   val_ext;

    assign tick    = (cnt == BIST_CNT_W'(BIST_PERIOD - 1));
    assign sum     = {1'b0, val} + {{(BIST_W - BIST_INC_W + 1){1'b0}}, rf_bist_inc};
    assign val_ext = {{(SAMPLE_W - BIST_W){1'b0}}, val};

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            cnt      <= '0;
            val      <= '0;
            bist_xfc <= 1'b0;
        end
        else if (!rf_bist_en)
        begin
            cnt      <= '0;
            val      <= rf_bist_start_val;              // First frame carries start value
            bist_xfc <= 1'b0;
        end
        else
        begin
            bist_xfc <= tick;
            cnt      <= tick ? '0 : cnt + 1'b1;
            if (tick)
                val <= (sum > {1'b0, rf_bist_up_limit}) ? rf_bist_start_val
                                                        : sum[BIST_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rf_bist_en && tick)
        begin
            bist_frame.left  <= val_ext;
            bist_frame.right <= val_ext;
        end
    end

endmodule

// File: hdl/i2si_collector.sv
`timescale 1ns/1ps

module i2si_collector
    import i2si_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  i2si_frame_t          port_frame [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] port_xfc,
    input  i2si_frame_t          bist_frame,
    input  logic                 bist_xfc,
    input  logic                 rf_bist_en,
    input  logic                 trig_fifo_overrun_clr,
    input  logic                 full,
    output i2si_word_t           wr_word,
    output logic                 wr,
    output logic                 ro_fifo_overrun
);

    logic [NUM_PORTS-1:0] pend_vld;
    i2si_frame_t          pend_frame [NUM_PORTS];
    logic                 bist_vld;
    i2si_frame_t          bist_hold;
    logic [NUM_PORTS-1:0] grant;                        // One-hot port grant
    logic                 grant_vld;
    logic [SRC_W-1:0]     grant_src;
    i2si_frame_t          grant_frame;
    logic [NUM_PORTS-1:0] accept;                       // Slot free or freed this cycle
    logic                 bist_acc;
    logic                 ovr_set;

    always_comb
    begin
        grant       = '0;
        grant_vld   = 1'b0;
        grant_src   = BIST_SRC;
        grant_frame = bist_hold;
        if (rf_bist_en)
            grant_vld = bist_vld;
        else
            for (int i = NUM_PORTS - 1; i >= 0; i--)    // Lowest index wins
            begin
                if (pend_vld[i])
                begin
                    grant       = '0;
                    grant[i]    = 1'b1;
                    grant_vld   = 1'b1;
                    grant_src   = SRC_W'(i);
                    grant_frame = pend_frame[i];
                end
            end
    end

    assign accept   = port_xfc & (~pend_vld | grant) & {NUM_PORTS{~rf_bist_en}};
    assign bist_acc = bist_xfc & rf_bist_en & (~bist_vld | grant_vld);
    assign ovr_set  = (grant_vld & full)
                    | (|(port_xfc & ~accept & {NUM_PORTS{~rf_bist_en}}))
                    | (bist_xfc & rf_bist_en & ~bist_acc);

    assign wr            = grant_vld & ~full;           // Granted frame dropped when full
    assign wr_word.src   = grant_src;
    assign wr_word.frame = grant_frame;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pend_vld        <= '0;
            bist_vld        <= 1'b0;
            ro_fifo_overrun <= 1'b0;
        end
        else
        begin
            pend_vld <= rf_bist_en ? '0 : (pend_vld & ~grant) | accept;
            if (!rf_bist_en)
                bist_vld <= 1'b0;
            else if (bist_acc)
                bist_vld <= 1'b1;
            else if (grant_vld)
                bist_vld <= 1'b0;
            if (ovr_set)
                ro_fifo_overrun <= 1'b1;
            else if (trig_fifo_overrun_clr)
                ro_fifo_overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (accept[i])
                pend_frame[i] <= port_frame[i];
        end
        if (bist_acc)
            bist_hold <= bist_frame;
    end

    // A frame dropped at a full FIFO always raises the flag, even against a clear
    a_drop_flagged: assert property (@(posedge clk) disable iff (!rst)
        grant_vld && full |=> ro_fifo_overrun);

endmodule

// File: hdl/i2si_fifo.sv
`timescale 1ns/1ps

module i2si_fifo
    import i2si_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  i2si_word_t wr_word,
    input  logic       wr,
    output logic       full,
    output i2si_word_t rd_word,
    output logic       rts,
    input  logic       rtr
);

    i2si_word_t            mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  push;
    logic                  pop;

    assign full    = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign rts     = (count != '0);
    assign rd_word = mem[rd_ptr];                       // Head valid while rts
    assign push    = wr & ~full;
    assign pop     = rtr & rts;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_word;
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst)
        count <= (FIFO_PTR_W + 1)'(FIFO_DEPTH));

endmodule

// File: hdl/i2s_in.sv
`timescale 1ns/1ps

module i2s_in
    import i2si_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_PORTS-1:0]  i2si_sck,
    input  logic [NUM_PORTS-1:0]  i2si_ws,
    input  logic [NUM_PORTS-1:0]  i2si_sd,
    input  logic                  rf_i2si_en,
    input  logic                  rf_bist_en,
    input  logic [BIST_W-1:0]     rf_bist_start_val,
    input  logic [BIST_W-1:0]     rf_bist_up_limit,
    input  logic [BIST_INC_W-1:0] rf_bist_inc,
    input  logic                  trig_fifo_overrun_clr,
    input  logic                  i2si_rtr,
    output i2si_word_t            i2si_data,
    output logic                  i2si_rts,
    output logic                  ro_fifo_overrun
);

    i2si_line_if          line_bus [NUM_PORTS] ();
    i2si_frame_t          port_frame [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_xfc;
    i2si_frame_t          bist_frame;
    logic                 bist_xfc;
    i2si_word_t           wr_word;
    logic                 wr;
    logic                 full;

    i2si_synchronizer u_sync (
        .clk       (clk),
        .rst       (rst),
        .i2si_sck  (i2si_sck),
        .i2si_ws   (i2si_ws),
        .i2si_sd   (i2si_sd),
        .i2si_en   (rf_i2si_en),
        .line      (line_bus)
    );

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_deser
        i2si_deserializer u_deser (
            .clk   (clk),
            .rst   (rst),
            .line  (line_bus[i]),
            .frame (port_frame[i]),
            .xfc   (port_xfc[i])
        );
    end

    i2si_bist_gen u_bist (
        .clk               (clk),
        .rst               (rst),
        .rf_bist_en        (rf_bist_en),
        .rf_bist_start_val (rf_bist_start_val),
        .rf_bist_up_limit  (rf_bist_up_limit),
        .rf_bist_inc       (rf_bist_inc),
        .bist_frame        (bist_frame),
        .bist_xfc          (bist_xfc)
    );

    i2si_collector u_coll (
        .clk                   (clk),
        .rst                   (rst),
        .port_frame            (port_frame),
        .port_xfc              (port_xfc),
        .bist_frame            (bist_frame),
        .bist_xfc              (bist_xfc),
        .rf_bist_en            (rf_bist_en),
        .trig_fifo_overrun_clr (trig_fifo_overrun_clr),
        .full                  (full),
        .wr_word               (wr_word),
        .wr                    (wr),
        .ro_fifo_overrun       (ro_fifo_overrun)
    );

    i2si_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_word (wr_word),
        .wr      (wr),
        .full    (full),
        .rd_word (i2si_data),
        .rts     (i2si_rts),
        .rtr     (i2si_rtr)
    );

endmodule

// File: tb/tb_i2s_in.sv
`timescale 1ns/1ps

module tb_i2s_in
    import i2si_pkg::*;
();

    localparam int SENT_FRAMES = 30;                    // All frames sent by the tests below
    localparam int CYCLE_LIMIT = 3000 * SENT_FRAMES + 2000;

    logic                  clk;
    logic                  rst;
    logic [NUM_PORTS-1:0]  i2si_sck;
    logic [NUM_PORTS-1:0]  i2si_ws;
    logic [NUM_PORTS-1:0]  i2si_sd;
    logic                  rf_i2si_en;
    logic                  rf_bist_en;
    logic [BIST_W-1:0]     rf_bist_start_val;
    logic [BIST_W-1:0]     rf_bist_up_limit;
    logic [BIST_INC_W-1:0] rf_bist_inc;
    logic                  trig_fifo_overrun_clr;
    logic                  i2si_rtr;
    i2si_word_t            i2si_data;
    logic                  i2si_rts;
    logic                  ro_fifo_overrun;

    i2si_frame_t exp_q [NUM_PORTS][$];                  // Frames the DUT must deliver, per port
    logic        last_ws [NUM_PORTS];
    logic        locked [NUM_PORTS];                    // Port has seen a ws fall while enabled
    logic        prev_lsb [NUM_PORTS];
    int          seed = 52974;
    int          errors = 0;
    int          cycles = 0;
    int          bist_exp;
    int          bist_cnt;
    string       test_name = "reset";

    i2s_in dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout in %s: the DUT stopped delivering frames", test_name);
            $display("Errors found");
            $finish;
        end
    end

    // Head is stable at the falling edge and pops on the next rising edge
    always @(negedge clk)
    begin
        if (rst && i2si_rts && i2si_rtr)
            take_word(i2si_data);
    end

    task automatic check(input string what, input logic [31:0] expv, input logic [31:0] actv);
        if (expv !== actv)
        begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, expv, actv);
        end
    endtask

    task automatic take_word(input i2si_word_t w);
        if (w.src == BIST_SRC)
        begin
            check("bist_left", 32'(bist_exp), 32'(w.frame.left));
            check("bist_right", 32'(bist_exp), 32'(w.frame.right));
            bist_cnt++;
            if (bist_exp + rf_bist_inc > rf_bist_up_limit)
                bist_exp = rf_bist_start_val;           // Ramp wraps to start
            else
                bist_exp = bist_exp + rf_bist_inc;
        end
        else if (w.src >= NUM_PORTS || exp_q[w.src].size() == 0)
        begin
            errors++;
            $display("In %s a frame with tag %0d arrived that was never sent", test_name, w.src);
        end
        else
            check("frame", exp_q[w.src].pop_front(), w.frame);
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // One bit clock period, ws and sd change while sck is low
    task automatic send_slot(input int p, input logic ws, input logic sd);
        if (last_ws[p] && !ws)
            locked[p] = rf_i2si_en;
        last_ws[p]  = ws;
        i2si_sck[p] = 1'b0;
        i2si_ws[p]  = ws;
        i2si_sd[p]  = sd;
        step(4);
        i2si_sck[p] = 1'b1;
        step(4);
    endtask

    task automatic send_frames(input int p, input int n);
        i2si_frame_t f;
        for (int i = 0; i < n; i++)
        begin
            f.left  = 16'($random(seed));
            f.right = 16'($random(seed));
            send_slot(p, 1'b0, prev_lsb[p]);            // Carries LSB of the previous right word
            if (locked[p] && rf_i2si_en && !rf_bist_en)
                exp_q[p].push_back(f);
            for (int k = 1; k < 32; k++)
                send_slot(p, k >= 16, (k <= 16) ? f.left[16-k] : f.right[32-k]);
            prev_lsb[p] = f.right[0];
        end
        send_slot(p, 1'b0, prev_lsb[p]);                // ws fall closes the last frame
        i2si_sck[p] = 1'b0;
        step(4);                                        // Lets the last frame reach the FIFO
    endtask

    task automatic wait_drained();
        int left;
        left = 1;
        while (left != 0)
        begin
            step(1);
            left = i2si_rts;
            for (int p = 0; p < NUM_PORTS; p++)
                left += exp_q[p].size();
        end
        step(1);
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b0;
        i2si_sck = '0;
        i2si_ws = '0;
        i2si_sd = '0;
        rf_i2si_en = 1'b1;
        rf_bist_en = 1'b0;
        rf_bist_start_val = 12'd10;
        rf_bist_up_limit = 12'd40;
        rf_bist_inc = 8'd7;
        trig_fifo_overrun_clr = 1'b0;
        i2si_rtr = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            last_ws[p]  = 1'b0;
            locked[p]   = 1'b0;
            prev_lsb[p] = 1'b0;
        end
        step(16);
        rst = 1'b1;
        step(2);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            send_slot(p, 1'b1, 1'b0);                   // ws high then low locks the port
            send_slot(p, 1'b0, 1'b0);
        end

        test_name = "port0_only";
        send_frames(0, 5);
        wait_drained();

        test_name = "two_ports";
        fork
            send_frames(0, 4);
            send_frames(1, 4);
        join
        wait_drained();

        test_name = "enable";
        rf_i2si_en = 1'b0;
        locked[0]  = 1'b0;
        send_frames(0, 2);
        rf_i2si_en = 1'b1;
        send_frames(0, 3);                              // First one only finds the ws edge
        wait_drained();

        test_name = "bist";
        bist_exp   = rf_bist_start_val;
        bist_cnt   = 0;
        rf_bist_en = 1'b1;
        send_frames(0, 2);
        while (bist_cnt < 6)
            step(1);
        rf_bist_en = 1'b0;
        wait_drained();

        test_name = "overrun";
        i2si_rtr = 1'b0;
        send_frames(0, 10);
        check("flag_set", 32'd1, 32'(ro_fifo_overrun));
        while (exp_q[0].size() > FIFO_DEPTH)
            exp_q[0].delete(exp_q[0].size() - 1);       // Frames past a full FIFO are lost
        i2si_rtr = 1'b1;
        wait_drained();
        trig_fifo_overrun_clr = 1'b1;
        step(1);
        trig_fifo_overrun_clr = 1'b0;
        step(1);
        check("flag_clear", 32'd0, 32'(ro_fifo_overrun));

        $display("Run complete after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: build.f
hdl/i2si_pkg.sv
hdl/i2si_line_if.sv
hdl/i2si_synchronizer.sv
hdl/i2si_deserializer.sv
hdl/i2si_bist_gen.sv
hdl/i2si_collector.sv
hdl/i2si_fifo.sv
hdl/i2s_in.sv
tb/tb_i2s_in.sv
